// File: filelist.f
rtl/merge_pkg.sv
rtl/sync_fifo.sv
rtl/merge_control.sv
rtl/lane_gather.sv
rtl/merge_assembler.sv
rtl/merge_data_generator.sv
test/tb_merge_data_generator.sv

// File: Makefile
# Verilator simulation of the merge data generator testbench

TOP := tb_merge_data_generator

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f filelist.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: test/tb_merge_data_generator.sv
// Testbench for the merge data generator with reference lane queues and checking assertions
`timescale 1ns/100ps
`default_nettype none

module tb_merge_data_generator import merge_pkg::*; ();

    localparam int DRIVE_DELAY = 1;
    localparam int TIMEOUT     = 2000;

    logic               ap_clk;
    logic               areset_generator;
    logic               start;
    logic               config_valid;
    lane_mask_t         config_mask;
    logic [COUNT_W-1:0] config_count;
    logic               config_request;
    logic               busy;
    logic               done;
    lane_mask_t         lane_valid;
    logic [META_W-1:0]  lane_meta  [MERGE_LANES];
    logic [FIELD_W-1:0] lane_field [MERGE_LANES];
    lane_mask_t         lane_prog_full;
    logic               out_pop;
    logic               out_valid;
    merged_packet_t     out_packet;

    // Words expected on the output, one queue per selected lane
    lane_word_t ref_q [MERGE_LANES][$];
    lane_mask_t cur_mask;
    int         fires;
    int         dones;
    int         received;

    merge_data_generator DUT (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .config_valid     (config_valid),
        .config_mask      (config_mask),
        .config_count     (config_count),
        .config_request   (config_request),
        .busy             (busy),
        .done             (done),
        .lane_valid       (lane_valid),
        .lane_meta        (lane_meta),
        .lane_field       (lane_field),
        .lane_prog_full   (lane_prog_full),
        .out_pop          (out_pop),
        .out_valid        (out_valid),
        .out_packet       (out_packet)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic fail_run(input string what);
        $display(">>> FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic step_cycle();
        @(posedge ap_clk);
        #(DRIVE_DELAY);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    // Selected fields against their queues, meta against lane 0
    task automatic check_packet(input merged_packet_t pkt);
        lane_word_t expected;
        for (int i = 0; i < MERGE_LANES; i++) begin
            if (cur_mask[i]) begin
                assert (ref_q[i].size() != 0) else
                    fail_run($sformatf("Output packet with no word queued on lane %0d", i));
                expected = ref_q[i].pop_front();
                if (i == 0) begin
                    expect_equal("out_packet.meta", 32'(pkt.meta), 32'(expected.meta));
                end
                expect_equal($sformatf("out_packet.field[%0d]", i), pkt.field[i],
                             expected.field);
            end
        end
    endtask

    always @(posedge ap_clk) begin
        if (!areset_generator) begin
            if (DUT.merge_fire) fires++;
            if (done) dones++;
            if (out_valid && out_pop) begin
                check_packet(out_packet);
                received++;
            end
        end
    end

    // --------------------
    // Concurrent checks
    // --------------------
    done_single_cycle : assert property (
        @(posedge ap_clk) disable iff (areset_generator) done |=> !done
    ) else fail_run("done stayed high for more than one cycle");

    busy_low_from_done : assert property (
        @(posedge ap_clk) disable iff (areset_generator) done |-> !busy ##1 !busy
    ) else fail_run("busy was high in or right after the done cycle");

    drained_lanes_empty : assert property (
        @(posedge ap_clk) disable iff (areset_generator) (lane_prog_full & ~cur_mask) == '0
    ) else fail_run("An unselected lane raised lane_prog_full");

    // At most two packets in flight once the output buffer reports nearly full
    out_buffer_bound : assert property (
        @(posedge ap_clk) disable iff (areset_generator)
            DUT.u_assembler.u_out_fifo.count <= PROG_THRESH + 2
    ) else fail_run("Output buffer grew past its nearly full level without a pause");

    // --------------------
    // Stimulus
    // --------------------
    // Selected lanes get count words each, tagged A; drained lanes get tag D
    task automatic feed_lanes(input lane_mask_t m, input int count);
        int         pushed [MERGE_LANES];
        int         cycles;
        bit         all_done;
        lane_word_t w;
        for (int i = 0; i < MERGE_LANES; i++) pushed[i] = 0;
        cycles   = 0;
        all_done = 1'b0;
        while (!all_done) begin
            if (cycles >= TIMEOUT) begin
                fail_run("Lane words were not accepted before the timeout");
            end else begin
                all_done = 1'b1;
                for (int i = 0; i < MERGE_LANES; i++) begin
                    lane_valid[i] = 1'b0;
                    w.meta = 16'($urandom);
                    if (m[i] && pushed[i] < count) begin
                        all_done = 1'b0;
                        if (!lane_prog_full[i] && $urandom_range(0, 3) != 0) begin
                            w.field = {8'hA0 | 8'(i), 24'($urandom)};
                            ref_q[i].push_back(w);
                            pushed[i]++;
                            lane_valid[i] = 1'b1;
                        end
                    end else if (!m[i] && !lane_prog_full[i] && $urandom_range(0, 1) != 0) begin
                        w.field = {8'hD0 | 8'(i), 24'($urandom)};
                        lane_valid[i] = 1'b1;
                    end
                    lane_meta[i]  = w.meta;
                    lane_field[i] = w.field;
                end
                step_cycle();
                cycles++;
            end
        end
        lane_valid = '0;
    endtask

    // Held low for hold cycles, then high; random level when hold is zero
    task automatic drive_out_pop(input int hold, input int target);
        int cycles;
        cycles = 0;
        while (received < target) begin
            if (cycles >= TIMEOUT) begin
                fail_run("Output packets did not arrive before the timeout");
            end else begin
                if (cycles < hold) out_pop = 1'b0;
                else if (hold > 0) out_pop = 1'b1;
                else out_pop = ($urandom_range(0, 3) != 0);
                step_cycle();
                cycles++;
            end
        end
        out_pop = 1'b0;
    endtask

    task automatic wait_for_done(input int target_fires);
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles >= TIMEOUT) begin
                fail_run("done did not pulse before the timeout");
            end else begin
                step_cycle();
                cycles++;
            end
        end
        expect_equal("merge_fire count at done", 32'(fires), 32'(target_fires));
        expect_equal("busy", 32'(busy), 32'h0);
    endtask

    task automatic run_merge(input lane_mask_t m, input int count, input int hold);
        int eff_count;
        int fires_start;
        int dones_start;
        int received_start;
        eff_count      = (count == 0) ? 1 : count;
        fires_start    = fires;
        dones_start    = dones;
        received_start = received;
        start = 1'b1;
        step_cycle();
        start = 1'b0;
        expect_equal("config_request", 32'(config_request), 32'h1);
        step_cycle();
        expect_equal("config_request", 32'(config_request), 32'h0);
        cur_mask     = m;
        config_mask  = m;
        config_count = COUNT_W'(count);
        config_valid = 1'b1;
        step_cycle();
        config_valid = 1'b0;
        expect_equal("busy", 32'(busy), 32'h1);
        fork
            feed_lanes(m, eff_count);
            drive_out_pop(hold, received_start + eff_count);
            wait_for_done(fires_start + eff_count);
        join
        repeat (3) step_cycle();
        expect_equal("done pulse count", 32'(dones - dones_start), 32'h1);
        expect_equal("merge_fire count", 32'(fires - fires_start), 32'(eff_count));
        for (int i = 0; i < MERGE_LANES; i++) begin
            expect_equal($sformatf("lane %0d words left", i), 32'(ref_q[i].size()), 32'h0);
        end
    endtask

    initial begin
        lane_mask_t partial;
        void'($urandom(32'h9340f6b0));
        areset_generator = 1'b1;
        start            = 1'b0;
        config_valid     = 1'b0;
        config_mask      = '0;
        config_count     = '0;
        lane_valid       = '0;
        out_pop          = 1'b0;
        cur_mask         = '0;
        fires            = 0;
        dones            = 0;
        received         = 0;
        for (int i = 0; i < MERGE_LANES; i++) begin
            lane_meta[i]  = '0;
            lane_field[i] = '0;
        end
        repeat (5) @(posedge ap_clk);
        #(DRIVE_DELAY);
        areset_generator = 1'b0;

        // Reset values
        expect_equal("busy", 32'(busy), 32'h0);
        expect_equal("done", 32'(done), 32'h0);
        expect_equal("config_request", 32'(config_request), 32'h0);
        expect_equal("out_valid", 32'(out_valid), 32'h0);
        expect_equal("lane_prog_full", 32'(lane_prog_full), 32'h0);

        run_merge('1, 6, 0);
        // Lane 0 always in, never all four lanes
        partial = lane_mask_t'({$urandom_range(0, 6), 1'b1});
        run_merge(partial, 8, 0);
        run_merge('1, 12, 40);
        run_merge(4'b0011, 0, 0);

        $display(">>> PASS");
        $finish;
    end

endmodule : tb_merge_data_generator

`default_nettype wire

// File: rtl/merge_data_generator.sv
// Merge data generator top level with control, lane gatherer and assembler
`timescale 1ns/100ps
`default_nettype none

module merge_data_generator import merge_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               start,
    input  logic               config_valid,
    input  lane_mask_t         config_mask,
    input  logic [COUNT_W-1:0] config_count,
    output logic               config_request,
    output logic               busy,
    output logic               done,
    input  lane_mask_t         lane_valid,
    input  logic [META_W-1:0]  lane_meta  [MERGE_LANES],
    input  logic [FIELD_W-1:0] lane_field [MERGE_LANES],
    output lane_mask_t         lane_prog_full,
    input  logic               out_pop,
    output logic               out_valid,
    output merged_packet_t     out_packet
);

    logic       active;
    lane_mask_t mask;
    logic       complete;
    lane_word_t captured [MERGE_LANES];
    logic       merge_fire;
    logic       out_prog_full;

    // --------------------
    // Control
    // --------------------
    merge_control u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .config_valid     (config_valid),
        .config_mask      (config_mask),
        .config_count     (config_count),
        .merge_fire       (merge_fire),
        .out_prog_full    (out_prog_full),
        .config_request   (config_request),
        .busy             (busy),
        .done             (done),
        .active           (active),
        .mask             (mask)
    );

    // --------------------
    // Lane gathering
    // --------------------
    lane_gather u_gather (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .lane_valid       (lane_valid),
        .lane_meta        (lane_meta),
        .lane_field       (lane_field),
        .active           (active),
        .mask             (mask),
        .merge_fire       (merge_fire),
        .lane_prog_full   (lane_prog_full),
        .captured         (captured),
        .complete         (complete)
    );

    // Packet build and output buffer
    merge_assembler u_assembler (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .complete         (complete),
        .captured         (captured),
        .out_pop          (out_pop),
        .merge_fire       (merge_fire),
        .out_prog_full    (out_prog_full),
        .out_valid        (out_valid),
        .out_packet       (out_packet)
    );

endmodule : merge_data_generator

`default_nettype wire

// File: rtl/merge_assembler.sv
// Merged packet build, merge fire pulse and output buffer
`timescale 1ns/100ps
`default_nettype none

module merge_assembler import merge_pkg::*; (
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           complete,
    input  lane_word_t     captured [MERGE_LANES],
    input  logic           out_pop,
    output logic           merge_fire,
    output logic           out_prog_full,
    output logic           out_valid,
    output merged_packet_t out_packet
);

    merged_packet_t packet;
    logic           pop;

    // --------------------
    // Fire pulse
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            merge_fire <= 1'b0;
        end else begin
            merge_fire <= complete;
        end
    end

    // Meta word from lane 0, one field per lane
    always_comb begin
        packet.meta = captured[0].meta;
        for (int i = 0; i < MERGE_LANES; i++) begin
            packet.field[i] = captured[i].field;
        end
    end

    assign pop = out_pop & out_valid;

    // --------------------
    // Output buffer
    // --------------------
    sync_fifo #(
        .payload_t (merged_packet_t),
        .DEPTH     (FIFO_DEPTH),
        .THRESH    (PROG_THRESH)
    ) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (merge_fire),
        .push_data        (packet),
        .pop              (pop),
        .head             (out_packet),
        .valid            (out_valid),
        .full             (),
        .prog_full        (out_prog_full)
    );

    // The gatherer has to drop complete while its captures clear
    fire_not_back_to_back : assert property (
        @(posedge ap_clk) disable iff (areset_generator) merge_fire |=> !merge_fire
    ) else $error("merge_assembler: merge_fire in two cycles in a row");

endmodule : merge_assembler

`default_nettype wire

// File: rtl/lane_gather.sv
// Per-lane input buffers, mask-driven pop and drain, and per-lane capture registers
`timescale 1ns/100ps
`default_nettype none

module lane_gather import merge_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  lane_mask_t         lane_valid,
    input  logic [META_W-1:0]  lane_meta  [MERGE_LANES],
    input  logic [FIELD_W-1:0] lane_field [MERGE_LANES],
    input  logic               active,
    input  lane_mask_t         mask,
    input  logic               merge_fire,
    output lane_mask_t         lane_prog_full,
    output lane_word_t         captured   [MERGE_LANES],
    output logic               complete
);

    lane_word_t head [MERGE_LANES];
    lane_mask_t head_valid;
    lane_mask_t pop;
    lane_mask_t take;
    lane_mask_t captured_q;

    genvar i;

    generate
        for (i = 0; i < MERGE_LANES; i++) begin : gen_lane
            lane_word_t push_word;

            assign push_word = '{meta: lane_meta[i], field: lane_field[i]};

            // --------------------
            // Input buffer
            // --------------------
            sync_fifo #(
                .payload_t (lane_word_t),
                .DEPTH     (FIFO_DEPTH),
                .THRESH    (PROG_THRESH)
            ) u_lane_fifo (
                .ap_clk           (ap_clk),
                .areset_generator (areset_generator),
                .push             (lane_valid[i]),
                .push_data        (push_word),
                .pop              (pop[i]),
                .head             (head[i]),
                .valid            (head_valid[i]),
                .full             (),
                .prog_full        (lane_prog_full[i])
            );

            // Selected lanes capture once per merge, others just drain
            assign take[i] = head_valid[i] & mask[i] & active & ~captured_q[i];
            assign pop[i]  = take[i] | (head_valid[i] & ~mask[i]);

            always_ff @(posedge ap_clk) begin
                if (areset_generator) begin
                    captured_q[i] <= 1'b0;
                end else if (merge_fire) begin
                    captured_q[i] <= 1'b0;
                end else if (take[i]) begin
                    captured_q[i] <= 1'b1;
                end
            end

            // Capture register
            always_ff @(posedge ap_clk) begin
                if (take[i]) begin
                    captured[i] <= head[i];
                end
            end
        end
    endgenerate

    // Unselected lanes count as present
    // Captures clear only after the fire cycle, so complete drops during it
    assign complete = active & ~merge_fire & (&(captured_q | ~mask));

endmodule : lane_gather

`default_nettype wire

// File: rtl/merge_control.sv
// Run control FSM with configuration request, packet counter, pause and done
`timescale 1ns/100ps
`default_nettype none

module merge_control import merge_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               start,
    input  logic               config_valid,
    input  lane_mask_t         config_mask,
    input  logic [COUNT_W-1:0] config_count,
    input  logic               merge_fire,
    input  logic               out_prog_full,
    output logic               config_request,
    output logic               busy,
    output logic               done,
    output logic               active,
    output lane_mask_t         mask
);

    merge_state_t       state;
    merge_state_t       next_state;
    logic [COUNT_W-1:0] target;
    logic [COUNT_W-1:0] fire_count;
    logic               last_fire;

    // Count-th merge of the run
    assign last_fire = merge_fire & (fire_count == target - 1'b1);

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= MERGE_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MERGE_IDLE: begin
                if (start) next_state = MERGE_REQ_CONFIG;
            end
            MERGE_REQ_CONFIG: begin
                next_state = MERGE_WAIT_CONFIG;
            end
            MERGE_WAIT_CONFIG: begin
                if (config_valid) next_state = MERGE_BUSY;
            end
            MERGE_BUSY: begin
                if (last_fire) next_state = MERGE_DONE;
                else if (out_prog_full) next_state = MERGE_PAUSE;
            end
            MERGE_PAUSE: begin
                // Merges already in flight still count here
                if (last_fire) next_state = MERGE_DONE;
                else if (!out_prog_full) next_state = MERGE_BUSY;
            end
            MERGE_DONE: begin
                next_state = MERGE_IDLE;
            end
            default: next_state = MERGE_IDLE;
        endcase
    end

    // --------------------
    // Configuration and counter
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            mask       <= '0;
            fire_count <= '0;
        end else if (state == MERGE_WAIT_CONFIG && config_valid) begin
            mask       <= config_mask;
            fire_count <= '0;
        end else if (merge_fire && busy) begin
            fire_count <= fire_count + 1'b1;
        end
    end

    // Zero count runs as a single packet
    always_ff @(posedge ap_clk) begin
        if (state == MERGE_WAIT_CONFIG && config_valid) begin
            target <= (config_count == '0) ? COUNT_W'(1) : config_count;
        end
    end

    assign config_request = (state == MERGE_REQ_CONFIG);
    assign busy           = (state == MERGE_BUSY) || (state == MERGE_PAUSE);
    assign done           = (state == MERGE_DONE);
    assign active         = busy & ~out_prog_full;

endmodule : merge_control

`default_nettype wire

// File: rtl/sync_fifo.sv
// Synchronous first-word-fall-through buffer with a payload type parameter and a prog full flag
`timescale 1ns/100ps
`default_nettype none

module sync_fifo import merge_pkg::*; #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = FIFO_DEPTH,
    parameter int  THRESH    = PROG_THRESH
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     valid,
    output logic     full,
    output logic     prog_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic     [PTR_W-1:0] wr_ptr;
    logic     [PTR_W-1:0] rd_ptr;
    logic     [CNT_W-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & valid;

    // --------------------
    // Status flags
    // --------------------
    assign valid     = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign prog_full = (count >= CNT_W'(THRESH));
    assign head      = mem[rd_ptr];

    // Payload storage
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------
    // Checks
    // --------------------
    no_push_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(push && full)
    ) else $error("sync_fifo: push while full");

    no_pop_when_empty : assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(pop && !valid)
    ) else $error("sync_fifo: pop while empty");

endmodule : sync_fifo

`default_nettype wire

// File: rtl/merge_pkg.sv
// Sizes, lane and packet types, and control state encoding for the merge data generator
`default_nettype none

package merge_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int MERGE_LANES = 4;
    localparam int FIELD_W     = 32;
    localparam int META_W      = 16;
    localparam int COUNT_W     = 16;
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    // --------------------
    // Types
    // --------------------
    // Set bit selects the lane for merging
    typedef logic [MERGE_LANES-1:0] lane_mask_t;

    typedef struct packed {
        logic [META_W-1:0]  meta;
        logic [FIELD_W-1:0] field;
    } lane_word_t;

    // Field i comes from lane i, meta from lane 0
    typedef struct packed {
        logic [META_W-1:0]                   meta;
        logic [MERGE_LANES-1:0][FIELD_W-1:0] field;
    } merged_packet_t;

    typedef enum logic [2:0] {
        MERGE_IDLE        = 3'd0,
        MERGE_REQ_CONFIG  = 3'd1,
        MERGE_WAIT_CONFIG = 3'd2,
        MERGE_BUSY        = 3'd3,
        MERGE_PAUSE       = 3'd4,
        MERGE_DONE        = 3'd5
    } merge_state_t;

endpackage : merge_pkg

`default_nettype wire
